// File: test/rtc_stim.txt
# mode, user s m h, timer s m h, planted s m h, expected time s m h, expected timer s m h
# values in hex; U writes the user time, T writes the timer and keeps the planted time
T 00 00 00 30 15 01 45 59 23 45 59 23 30 15 01
U 12 34 08 99 99 99 00 00 00 12 34 08 30 15 01
T 11 11 11 00 45 12 07 30 17 07 30 17 00 45 12
U 59 59 23 22 22 22 30 30 10 59 59 23 00 45 12
T 00 00 00 59 59 99 00 00 00 00 00 00 59 59 99
U 01 00 00 10 20 30 05 05 05 01 00 00 59 59 99
T 33 33 33 01 02 03 58 12 09 58 12 09 01 02 03
U 00 10 12 44 44 44 59 59 23 00 10 12 01 02 03

// File: flist.f
+incdir+source
source/rtcPkg.sv
source/mainControl.sv
source/rtcSequencer.sv
source/wbMaster.sv
source/rtcController.sv
test/rtcModel.sv
test/rtcControllerTb.sv

// File: run.sh
#!/bin/bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module rtcControllerTb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/VrtcControllerTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q -F '** FAIL **' sim.log; then
	exit 1
fi
exit 0

// File: test/rtcControllerTb.sv
`timescale 1ns/1ns
`include "rtc_consts.svh"

module rtcControllerTb;

	localparam int MaxLines = 32;

	logic              CLK;
	logic              reset;
	logic              wbCyc, wbStb, wbWe, wbAck;
	rtcPkg::regAddr_t  wbAdr;
	rtcPkg::regData_t  wbDatOut, wbDatIn;
	logic              refreshTick, userRequest, timeValid;
	rtcPkg::timeByte_t userSeconds, userMinutes, userHours;
	rtcPkg::timeByte_t timerSeconds, timerMinutes, timerHours;
	rtcPkg::timeByte_t seconds, minutes, hours;
	logic              pokeEn;
	rtcPkg::regAddr_t  pokeAddr;
	rtcPkg::regData_t  pokeData;

	// columns 0..14 of a stim line, after the mode letter
	logic [7:0] stimMode [0:MaxLines-1];
	logic [7:0] stimVal [0:MaxLines-1][0:14];
	int         lineCount;
	int         cycleCount = 0;
	int         cycleLimit = 0;
	int         validCount = 0;
	int         checkErrors = 0;
	int         testsRun = 0;
	int         testsFailed = 0;
	bit         testBad = 1'b0;

	rtcController dut_i (.*);

	rtcModel modelInst (.*);

	initial
	begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	always @(posedge CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
			$display("** FAIL **");
			$finish;
		end
	end

	always @(negedge CLK)
		if (timeValid)
			validCount <= validCount + 1;

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------

	task automatic driveEdge();
		@(posedge CLK);
		#2;
	endtask

	task automatic checkByte(input string what, input logic [7:0] got,
		input logic [7:0] expected);
		if (got !== expected)
		begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got,
				expected);
			checkErrors++;
			testBad = 1'b1;
		end
	endtask

	task automatic checkIdle(input string when);
		if (wbCyc !== 1'b0 || wbStb !== 1'b0 || timeValid !== 1'b0)
		begin
			$display("CHECK FAILED at %0t ns: wbCyc, wbStb or timeValid high %s", $time,
				when);
			checkErrors++;
			testBad = 1'b1;
		end
		checkByte({"seconds ", when}, seconds, 8'h00);
		checkByte({"minutes ", when}, minutes, 8'h00);
		checkByte({"hours ", when}, hours, 8'h00);
	endtask

	task automatic checkPulseCount(input int expected);
		if (validCount != expected)
		begin
			$display("CHECK FAILED at %0t ns: %0d timeValid pulses, expected %0d", $time,
				validCount, expected);
			checkErrors++;
			testBad = 1'b1;
		end
	endtask

	task automatic waitTimeValid();
		do
			@(negedge CLK);
		while (timeValid !== 1'b1);
	endtask

	task automatic endTest(input string name);
		$display("test %s: %s", name, testBad ? "failed" : "ok");
		testsRun++;
		if (testBad)
			testsFailed++;
		testBad = 1'b0;
	endtask

	task automatic loadStim(output bit ok);
		int    fd;
		int    got;
		bit    malformed;
		string line;
		ok = 1'b0;
		malformed = 1'b0;
		lineCount = 0;
		fd = $fopen("test/rtc_stim.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd) && lineCount < MaxLines)
		begin
			line = "";
			got = $fgets(line, fd);
			if (line.len() > 2 && line[0] != "#")
			begin
				stimMode[lineCount] = line[0];
				got = $sscanf(line.substr(2, line.len() - 1),
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					stimVal[lineCount][0], stimVal[lineCount][1], stimVal[lineCount][2],
					stimVal[lineCount][3], stimVal[lineCount][4], stimVal[lineCount][5],
					stimVal[lineCount][6], stimVal[lineCount][7], stimVal[lineCount][8],
					stimVal[lineCount][9], stimVal[lineCount][10], stimVal[lineCount][11],
					stimVal[lineCount][12], stimVal[lineCount][13], stimVal[lineCount][14]);
				if (got == 15)
					lineCount++;
				else
					malformed = 1'b1;
			end
		end
		$fclose(fd);
		ok = (lineCount > 0) && !malformed;
		cycleLimit = lineCount * 200 + 500;
	endtask

	// ----------------------------------------------------------------------
	// one refresh step from the stim file
	// ----------------------------------------------------------------------

	task automatic runLine(input int n);
		userRequest = (stimMode[n] == "U");
		userSeconds = stimVal[n][0];
		userMinutes = stimVal[n][1];
		userHours = stimVal[n][2];
		timerSeconds = stimVal[n][3];
		timerMinutes = stimVal[n][4];
		timerHours = stimVal[n][5];
		for (int k = 0; k < `TIME_REG_COUNT; k++)
		begin
			driveEdge();
			pokeEn = 1'b1;
			pokeAddr = `RTC_TIME_BASE + 8'(k);
			pokeData = stimVal[n][6 + k];
		end
		driveEdge();
		pokeEn = 1'b0;
		checkPulseCount(n + 1);	// one pulse after init plus one per earlier line
		refreshTick = 1'b1;	// main control sits in stable here
		driveEdge();
		refreshTick = 1'b0;
		waitTimeValid();
		checkByte("seconds", seconds, stimVal[n][9]);
		checkByte("minutes", minutes, stimVal[n][10]);
		checkByte("hours", hours, stimVal[n][11]);
		for (int k = 0; k < `TIME_REG_COUNT; k++)
		begin
			checkByte("time register", modelInst.regs[`RTC_TIME_BASE + 8'(k)],
				stimVal[n][9 + k]);
			checkByte("timer register", modelInst.regs[`RTC_TIMER_BASE + 8'(k)],
				stimVal[n][12 + k]);
		end
		repeat (3) driveEdge();
		checkPulseCount(n + 2);
	endtask

	initial
	begin
		bit loaded;
		reset = 1'b1;
		refreshTick = 1'b0;
		userRequest = 1'b0;
		{userSeconds, userMinutes, userHours} = '0;
		{timerSeconds, timerMinutes, timerHours} = '0;
		pokeEn = 1'b0;
		pokeAddr = '0;
		pokeData = '0;
		loadStim(loaded);
		if (!loaded)
		begin
			$display("stimulus file test/rtc_stim.txt is missing, empty or malformed");
			$display("** FAIL **");
		end
		else
		begin
			repeat (4)
			begin
				@(negedge CLK);
				checkIdle("during reset");
			end
			@(posedge CLK);	// fifth edge under reset
			#2;
			reset = 1'b0;
			@(negedge CLK);
			checkIdle("after reset");
			endTest("reset");

			waitTimeValid();
			checkByte("seconds", seconds, 8'h00);
			checkByte("minutes", minutes, 8'h00);
			checkByte("hours", hours, 8'h00);
			checkByte("control register", modelInst.regs[`RTC_CTRL_ADDR], `RTC_CTRL_RUN_VALUE);
			repeat (3) driveEdge();
			checkPulseCount(1);
			endTest("init and clear");

			for (int n = 0; n < lineCount; n++)
			begin
				runLine(n);
				endTest($sformatf("line %0d (%c)", n + 1, stimMode[n]));
			end

			$display("tests run %0d, tests failed %0d, failed checks %0d", testsRun,
				testsFailed, checkErrors);
			if (checkErrors == 0)
				$display("** PASS **");
			else
				$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: test/rtcModel.sv
`timescale 1ns/1ns

module rtcModel
(
	input  logic             CLK,
	input  logic             reset,
	input  logic             wbCyc,
	input  logic             wbStb,
	input  logic             wbWe,
	input  rtcPkg::regAddr_t wbAdr,
	input  rtcPkg::regData_t wbDatOut,
	output rtcPkg::regData_t wbDatIn,
	output logic             wbAck,
	input  logic             pokeEn,	// backdoor write, bypasses the bus
	input  rtcPkg::regAddr_t pokeAddr,
	input  rtcPkg::regData_t pokeData
);

	rtcPkg::regData_t regs [0:255];
	logic [31:0]      rngState;
	logic [1:0]       waitLeft;
	logic             busy;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	always @(posedge CLK)
	begin
		if (reset)
		begin
			wbAck <= 1'b0;
			wbDatIn <= '0;
			busy <= 1'b0;
			waitLeft <= '0;
			rngState <= 32'd91;
			for (int i = 0; i < 256; i++)
				regs[i] <= 8'(i) ^ 8'h5a;	// every register starts with a distinct value
		end
		else
		begin
			wbAck <= 1'b0;
			if (pokeEn)
				regs[pokeAddr] <= pokeData;
			if (wbCyc && wbStb && !wbAck && !busy)
			begin
				busy <= 1'b1;
				waitLeft <= rngState[1:0];	// zero to three wait states
				rngState <= xorshift32(rngState);
			end
			else if (busy && waitLeft != 2'd0)
				waitLeft <= waitLeft - 2'd1;
			else if (busy)
			begin
				busy <= 1'b0;
				wbAck <= 1'b1;
				if (wbWe)
					regs[wbAdr] <= wbDatOut;
				else
					wbDatIn <= regs[wbAdr];
			end
		end
	end

endmodule

// File: source/rtcController.sv
`timescale 1ns/1ns

module rtcController
(
	input  logic              CLK,
	input  logic              reset,
	output logic              wbCyc,
	output logic              wbStb,
	output logic              wbWe,
	output rtcPkg::regAddr_t  wbAdr,
	output rtcPkg::regData_t  wbDatOut,
	input  rtcPkg::regData_t  wbDatIn,
	input  logic              wbAck,
	input  logic              refreshTick,
	input  logic              userRequest,
	input  rtcPkg::timeByte_t userSeconds,
	input  rtcPkg::timeByte_t userMinutes,
	input  rtcPkg::timeByte_t userHours,
	input  rtcPkg::timeByte_t timerSeconds,
	input  rtcPkg::timeByte_t timerMinutes,
	input  rtcPkg::timeByte_t timerHours,
	output rtcPkg::timeByte_t seconds,
	output rtcPkg::timeByte_t minutes,
	output rtcPkg::timeByte_t hours,
	output logic              timeValid
);

	logic initStart;
	logic clearStart;
	logic readStart;
	logic userStart;
	logic timerStart;
	logic initDone;
	logic writeDone;
	logic readDone;
	logic go;
	logic write;
	logic done;
	rtcPkg::regAddr_t addr;
	rtcPkg::regData_t dataOut;
	rtcPkg::regData_t dataIn;

	mainControl mainControlInst (.CLK, .reset, .initDone, .writeDone, .readDone,
		.refreshTick, .userRequest, .initStart, .clearStart, .readStart, .userStart,
		.timerStart);

	rtcSequencer sequencerInst (.CLK, .reset, .initStart, .clearStart, .readStart,
		.userStart, .timerStart, .userSeconds, .userMinutes, .userHours, .timerSeconds,
		.timerMinutes, .timerHours, .done, .dataIn, .initDone, .writeDone, .readDone,
		.go, .write, .addr, .dataOut, .seconds, .minutes, .hours, .timeValid);

	wbMaster busMasterInst (.CLK, .reset, .go, .write, .addr, .dataOut, .wbDatIn, .wbAck,
		.done, .dataIn, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatOut);

endmodule

// File: source/wbMaster.sv
`timescale 1ns/1ns

module wbMaster
(
	input  logic             CLK,
	input  logic             reset,
	input  logic             go,
	input  logic             write,
	input  rtcPkg::regAddr_t addr,
	input  rtcPkg::regData_t dataOut,
	input  rtcPkg::regData_t wbDatIn,
	input  logic             wbAck,
	output logic             done,
	output rtcPkg::regData_t dataIn,
	output logic             wbCyc,
	output logic             wbStb,
	output logic             wbWe,
	output rtcPkg::regAddr_t wbAdr,
	output rtcPkg::regData_t wbDatOut
);

	logic accept;
	logic finish;

	assign accept = go && !wbCyc;	// a go during a cycle is ignored
	assign finish = wbCyc && wbAck;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
			wbWe <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= finish;
			if (accept)
			begin
				wbCyc <= 1'b1;
				wbStb <= 1'b1;
				wbWe <= write;
			end
			else if (finish)
			begin
				wbCyc <= 1'b0;
				wbStb <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (accept)
		begin
			wbAdr <= addr;
			wbDatOut <= dataOut;
		end
		if (finish && !wbWe)
			dataIn <= wbDatIn;	// read data is held until the next read
	end

	// the slave may stretch the cycle, the request must not move meanwhile
	stbHeld: assert property (@(posedge CLK) disable iff (reset)
		(wbStb && !wbAck) |=> (wbStb && $stable(wbAdr)))
		else $error("strobe or address changed before ack");

endmodule

// File: source/rtcSequencer.sv
`timescale 1ns/1ns
`include "rtc_consts.svh"

module rtcSequencer
(
	input  logic              CLK,
	input  logic              reset,
	input  logic              initStart,
	input  logic              clearStart,
	input  logic              readStart,
	input  logic              userStart,
	input  logic              timerStart,
	input  rtcPkg::timeByte_t userSeconds,
	input  rtcPkg::timeByte_t userMinutes,
	input  rtcPkg::timeByte_t userHours,
	input  rtcPkg::timeByte_t timerSeconds,
	input  rtcPkg::timeByte_t timerMinutes,
	input  rtcPkg::timeByte_t timerHours,
	input  logic              done,
	input  rtcPkg::regData_t  dataIn,
	output logic              initDone,
	output logic              writeDone,
	output logic              readDone,
	output logic              go,
	output logic              write,
	output rtcPkg::regAddr_t  addr,
	output rtcPkg::regData_t  dataOut,
	output rtcPkg::timeByte_t seconds,
	output rtcPkg::timeByte_t minutes,
	output rtcPkg::timeByte_t hours,
	output logic              timeValid
);

	rtcPkg::seqState_t  state;
	rtcPkg::mainState_t prog;	// program being run, named after its main state
	rtcPkg::mainState_t newProg;
	logic [1:0]         idx;
	logic               lastXfer;
	logic               progLevel;
	logic               anyStart;
	rtcPkg::timeByte_t  readBuf [0:`TIME_REG_COUNT-2];

	function automatic rtcPkg::regData_t pickByte(input logic [1:0] sel,
		input rtcPkg::timeByte_t sec, input rtcPkg::timeByte_t min,
		input rtcPkg::timeByte_t hr);
		case (sel)
			2'd0: pickByte = sec;
			2'd1: pickByte = min;
			default: pickByte = hr;
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// program selection and transfer decode
	// ----------------------------------------------------------------------

	assign anyStart = initStart | clearStart | readStart | userStart | timerStart;

	always_comb
	begin
		if (initStart)
			newProg = rtcPkg::initChip;
		else if (clearStart)
			newProg = rtcPkg::clearTime;
		else if (readStart)
			newProg = rtcPkg::readTime;
		else if (userStart)
			newProg = rtcPkg::userWrite;
		else
			newProg = rtcPkg::timerWrite;
	end

	always_comb
	begin
		case (prog)
			rtcPkg::initChip: progLevel = initStart;
			rtcPkg::clearTime: progLevel = clearStart;
			rtcPkg::readTime: progLevel = readStart;
			rtcPkg::userWrite: progLevel = userStart;
			default: progLevel = timerStart;
		endcase
	end

	assign lastXfer = (prog == rtcPkg::initChip) ? (idx == 2'(`INIT_WRITE_COUNT - 1))
		: (idx == 2'(`TIME_REG_COUNT - 1));

	always_comb
	begin
		write = 1'b1;
		dataOut = '0;	// clearTime writes zeros
		addr = `RTC_TIME_BASE + rtcPkg::regAddr_t'(idx);
		case (prog)
			rtcPkg::initChip:
			begin
				addr = `RTC_CTRL_ADDR;
				dataOut = (idx == 2'd0) ? `RTC_CTRL_RESET_VALUE : `RTC_CTRL_RUN_VALUE;
			end
			rtcPkg::readTime:
				write = 1'b0;
			rtcPkg::userWrite:
				dataOut = pickByte(idx, userSeconds, userMinutes, userHours);
			rtcPkg::timerWrite:
			begin
				addr = `RTC_TIMER_BASE + rtcPkg::regAddr_t'(idx);
				dataOut = pickByte(idx, timerSeconds, timerMinutes, timerHours);
			end
			default:
				write = 1'b1;
		endcase
	end

	// ----------------------------------------------------------------------
	// sequencing
	// ----------------------------------------------------------------------

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= rtcPkg::idle;
			prog <= rtcPkg::initChip;
			idx <= '0;
			go <= 1'b0;
			initDone <= 1'b0;
			writeDone <= 1'b0;
			readDone <= 1'b0;
			timeValid <= 1'b0;
			seconds <= '0;
			minutes <= '0;
			hours <= '0;
		end
		else
		begin
			go <= 1'b0;
			initDone <= 1'b0;
			writeDone <= 1'b0;
			readDone <= 1'b0;
			timeValid <= 1'b0;
			case (state)
				rtcPkg::idle:
					if (anyStart)
					begin
						prog <= newProg;
						idx <= '0;
						go <= 1'b1;	// go is high exactly while in issue
						state <= rtcPkg::issue;
					end
				rtcPkg::issue:
					state <= rtcPkg::waitDone;
				rtcPkg::waitDone:
					if (done && !lastXfer)
					begin
						idx <= idx + 2'd1;
						go <= 1'b1;
						state <= rtcPkg::issue;
					end
					else if (done)
					begin
						state <= rtcPkg::releaseWait;
						case (prog)
							rtcPkg::initChip:
								initDone <= 1'b1;
							rtcPkg::readTime:
							begin
								readDone <= 1'b1;
								timeValid <= 1'b1;
								seconds <= readBuf[0];
								minutes <= readBuf[1];
								hours <= dataIn;	// last byte goes straight out
							end
							default:
								writeDone <= 1'b1;
						endcase
					end
				default:
					// the next program's level may already be up, only ours must drop
					if (!progLevel)
						state <= rtcPkg::idle;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == rtcPkg::waitDone && done && prog == rtcPkg::readTime && !lastXfer)
			readBuf[idx[0]] <= dataIn;
	end

	noGoInWait: assert property (@(posedge CLK) disable iff (reset)
		(state == rtcPkg::waitDone) |-> !go)
		else $error("go issued while a transfer is outstanding");

	doneOnlyInWait: assert property (@(posedge CLK) disable iff (reset)
		done |-> (state == rtcPkg::waitDone))
		else $error("bus done arrived with no transfer pending");

endmodule

// File: source/mainControl.sv
`timescale 1ns/1ns

module mainControl
(
	input  logic CLK,
	input  logic reset,
	input  logic initDone,
	input  logic writeDone,
	input  logic readDone,
	input  logic refreshTick,
	input  logic userRequest,
	output logic initStart,
	output logic clearStart,
	output logic readStart,
	output logic userStart,
	output logic timerStart
);

	rtcPkg::mainState_t state;
	rtcPkg::mainState_t nextState;

	// ----------------------------------------------------------------------
	// next state
	// ----------------------------------------------------------------------

	always_comb
	begin
		nextState = state;
		case (state)
			rtcPkg::initChip:
				if (initDone)
					nextState = rtcPkg::clearTime;
			rtcPkg::clearTime:
				if (writeDone)
					nextState = rtcPkg::readTime;
			rtcPkg::readTime:
				if (readDone)
					nextState = rtcPkg::stable;
			rtcPkg::stable:
				if (refreshTick)
					nextState = rtcPkg::request;
			rtcPkg::request:	// the only place the user choice is looked at
				if (userRequest)
					nextState = rtcPkg::userWrite;
				else
					nextState = rtcPkg::timerWrite;
			rtcPkg::userWrite:
				if (writeDone)
					nextState = rtcPkg::readTime;
			rtcPkg::timerWrite:
				if (writeDone)
					nextState = rtcPkg::readTime;
			default:
				nextState = rtcPkg::initChip;
		endcase
	end

	// ----------------------------------------------------------------------
	// state register and start levels
	// ----------------------------------------------------------------------

	// levels follow the state one cycle late
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= rtcPkg::initChip;
			initStart <= 1'b0;
			clearStart <= 1'b0;
			readStart <= 1'b0;
			userStart <= 1'b0;
			timerStart <= 1'b0;
		end
		else
		begin
			state <= nextState;
			initStart <= 1'b0;
			clearStart <= 1'b0;
			readStart <= 1'b0;
			userStart <= 1'b0;
			timerStart <= 1'b0;
			case (state)
				rtcPkg::initChip:
					initStart <= 1'b1;
				rtcPkg::clearTime:
					clearStart <= 1'b1;
				rtcPkg::readTime:
					readStart <= 1'b1;
				rtcPkg::userWrite:
					userStart <= 1'b1;
				rtcPkg::timerWrite:
					timerStart <= 1'b1;
				default:
					initStart <= 1'b0;	// stable and request start nothing
			endcase
		end
	end

	oneStartLevel: assert property (@(posedge CLK) disable iff (reset)
		$onehot0({initStart, clearStart, readStart, userStart, timerStart}))
		else $error("more than one start level is high");

endmodule

// File: source/rtcPkg.sv
package rtcPkg;

	typedef logic [7:0] timeByte_t;	// one BCD field, tens in the upper nibble
	typedef logic [7:0] regAddr_t;
	typedef logic [7:0] regData_t;

	// steps of the top-level program
	typedef enum logic [2:0]
	{
		initChip,
		clearTime,
		readTime,
		stable,
		request,
		userWrite,
		timerWrite
	} mainState_t;

	typedef enum logic [1:0]
	{
		idle,
		issue,
		waitDone,
		releaseWait	// finished, waiting for the start level to drop
	} seqState_t;

endpackage

// File: source/rtc_consts.svh
`ifndef RTC_CONSTS_SVH
`define RTC_CONSTS_SVH

// ----------------------------------------------------------------------
// register map of the clock chip
// ----------------------------------------------------------------------

`define RTC_CTRL_ADDR         8'h02
`define RTC_CTRL_RESET_VALUE  8'h10	// first init write holds the chip in reset
`define RTC_CTRL_RUN_VALUE    8'h00	// second init write lets it count

// seconds sit at the base, minutes and hours at the next two addresses
`define RTC_TIME_BASE         8'h21
`define RTC_TIMER_BASE        8'h41

// transfers per program
`define INIT_WRITE_COUNT      2
`define TIME_REG_COUNT        3

`endif
